// File: hw/etrocPllPkg.sv
// PLL feedback path definitions
`default_nettype none

package etrocPllPkg;

	//////////////////////////////
	// feedback divider
	//////////////////////////////

	// fast cycles per 40 MHz period
	localparam int DIV_RATIO = 64;
	localparam int FB_COUNT_W = 6;

	// count bits behind each derived clock
	localparam int CLK1G28_BIT = 0;
	localparam int CLK320M_BIT = 2;
	localparam int CLK40M_BIT = 5;

	//////////////////////////////
	// lock and phase
	//////////////////////////////

	// consecutive in-window reference edges for lock
	localparam int LOCK_COUNT = 8;
	localparam int LOCK_CNT_W = 4;

	// accepted phase distance in fast cycles
	localparam int PHASE_WINDOW = 1;

	// voted count in the first cycle the feedback clock is high
	// (half period plus the clock register)
	localparam int FB_EDGE_COUNT = DIV_RATIO / 2 + 1;

	typedef logic [FB_COUNT_W-1:0] fbCount_t;
	typedef logic [LOCK_CNT_W-1:0] lockCnt_t;

	typedef enum logic [1:0] {
		UNLOCKED,
		ACQUIRING,
		LOCKED
	} lockState_t;

endpackage

`default_nettype wire

// File: hw/fbDividerLane.sv
// Feedback divider lane
`timescale 1ns/1ns
`default_nettype none

module fbDividerLane import etrocPllPkg::*; (
	input  logic     clk2g56,
	input  logic     rstN,
	input  logic     enablePll,
	input  logic     skip,
	input  logic     skipVoted,
	input  fbCount_t countVoted,
	output fbCount_t count
);

	logic     hold;
	fbCount_t countNext;

	//////////////////////////////
	// next state
	//////////////////////////////

	// majority skip holds every lane together
	// a lone skip holds only this lane for one cycle
	assign hold = skip | skipVoted;

	// always step from the voted count so an upset lane rejoins
	// wraps at DIV_RATIO since the ratio is a power of two
	assign countNext = hold ? countVoted : countVoted + fbCount_t'(1);

	//////////////////////////////
	// count register
	//////////////////////////////

	// disabled PLL parks the lane at zero
	always_ff @(posedge clk2g56) begin
		if (!rstN || !enablePll) begin
			count <= '0;
		end else begin
			count <= countNext;
		end
	end

endmodule

`default_nettype wire

// File: hw/fbDividerTmr.sv
// Triplicated feedback divider
`timescale 1ns/1ns
`default_nettype none

module fbDividerTmr import etrocPllPkg::*; (
	input  logic     clk2g56,
	input  logic     rstN,
	input  logic     enablePll,
	input  logic     skipA,
	input  logic     skipB,
	input  logic     skipC,
	output fbCount_t fbCount,
	output logic     wrapPulse,
	output logic     clk1G28Raw,
	output logic     clk320MRaw,
	output logic     clk40MRaw,
	output logic     tmrErr
);

	logic [2:0] skipLane;
	logic       skipVoted;
	fbCount_t   laneCount [3];
	logic       laneMismatch;

	//////////////////////////////
	// skip vote
	//////////////////////////////

	assign skipLane = {skipC, skipB, skipA};

	assign skipVoted = (skipA & skipB) | (skipA & skipC) | (skipB & skipC);

	//////////////////////////////
	// lanes
	//////////////////////////////

	for (genvar i = 0; i < 3; i++) begin : gLane
		fbDividerLane uLane (
			.clk2g56    (clk2g56),
			.rstN       (rstN),
			.enablePll  (enablePll),
			.skip       (skipLane[i]),
			.skipVoted  (skipVoted),
			.countVoted (fbCount),
			.count      (laneCount[i])
		);
	end

	//////////////////////////////
	// count vote
	//////////////////////////////

	// bitwise majority of the three lanes
	assign fbCount = (laneCount[0] & laneCount[1])
		| (laneCount[0] & laneCount[2])
		| (laneCount[1] & laneCount[2]);

	// last cycle of the 40 MHz period
	assign wrapPulse = (fbCount == fbCount_t'(DIV_RATIO - 1));

	assign laneMismatch = (laneCount[0] != laneCount[1])
		|| (laneCount[1] != laneCount[2]);

	//////////////////////////////
	// derived clocks
	//////////////////////////////

	// one register after the voted count, no decode glitches
	always_ff @(posedge clk2g56) begin
		if (!rstN) begin
			clk1G28Raw <= 1'b0;
			clk320MRaw <= 1'b0;
			clk40MRaw  <= 1'b0;
		end else begin
			clk1G28Raw <= fbCount[CLK1G28_BIT];
			clk320MRaw <= fbCount[CLK320M_BIT];
			clk40MRaw  <= fbCount[CLK40M_BIT];
		end
	end

	//////////////////////////////
	// upset flag
	//////////////////////////////

	// sticky until reset, even across a disabled PLL
	always_ff @(posedge clk2g56) begin
		if (!rstN) begin
			tmrErr <= 1'b0;
		end else if (laneMismatch) begin
			tmrErr <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hw/clkTreeGate.sv
// Clock tree gate
`timescale 1ns/1ns
`default_nettype none

module clkTreeGate (
	input  logic       clk2g56,
	input  logic       rstN,
	input  logic [2:0] treeDisable,
	input  logic       wrapPulse,
	input  logic       clkIn,
	output logic       clkOut
);

	logic disableVoted;
	logic disableSampled;
	logic treeEn;

	//////////////////////////////
	// disable vote
	//////////////////////////////

	// copies A, B and C of the tree disable
	assign disableVoted = (treeDisable[0] & treeDisable[1])
		| (treeDisable[0] & treeDisable[2])
		| (treeDisable[1] & treeDisable[2]);

	//////////////////////////////
	// gating
	//////////////////////////////

	// disable only sampled at the counter wrap
	// enable switches in a low cycle of clkIn, so the next pulse
	// is either whole or missing
	always_ff @(posedge clk2g56) begin
		if (!rstN) begin
			disableSampled <= 1'b0;
			treeEn         <= 1'b1;
			clkOut         <= 1'b0;
		end else begin
			if (wrapPulse) begin
				disableSampled <= disableVoted;
			end
			if (!clkIn) begin
				treeEn <= ~disableSampled;
			end
			// same register delay on every tree
			clkOut <= clkIn & treeEn;
		end
	end

endmodule

`default_nettype wire

// File: hw/lockDetector.sv
// Feedback phase lock detector
`timescale 1ns/1ns
`default_nettype none

module lockDetector import etrocPllPkg::*; (
	input  logic     clk2g56,
	input  logic     rstN,
	input  logic     enablePll,
	input  logic     clk40Ref,
	input  fbCount_t fbCount,
	output logic     instLock
);

	logic       refQ;
	logic       refEdge;
	fbCount_t   phaseDiff;
	fbCount_t   phaseDist;
	logic       phaseMatch;
	lockState_t state;
	lockCnt_t   matchCnt;

	//////////////////////////////
	// reference edge
	//////////////////////////////

	always_ff @(posedge clk2g56) begin
		if (!rstN) begin
			refQ <= 1'b0;
		end else begin
			refQ <= clk40Ref;
		end
	end

	assign refEdge = clk40Ref & ~refQ;

	//////////////////////////////
	// phase window
	//////////////////////////////

	// offset from the count where the feedback edge shows up
	assign phaseDiff = fbCount - fbCount_t'(FB_EDGE_COUNT);

	// distance modulo the period, either direction
	assign phaseDist = phaseDiff[FB_COUNT_W-1] ? -phaseDiff : phaseDiff;

	assign phaseMatch = (phaseDist <= fbCount_t'(PHASE_WINDOW));

	//////////////////////////////
	// lock FSM
	//////////////////////////////

	always_ff @(posedge clk2g56) begin
		if (!rstN || !enablePll) begin
			state    <= UNLOCKED;
			matchCnt <= '0;
		end else if (refEdge) begin
			if (!phaseMatch) begin
				// one miss is enough to drop lock
				state    <= UNLOCKED;
				matchCnt <= '0;
			end else begin
				case (state)
					UNLOCKED: begin
						state    <= ACQUIRING;
						matchCnt <= lockCnt_t'(1);
					end
					ACQUIRING: begin
						if (matchCnt == lockCnt_t'(LOCK_COUNT - 1)) begin
							state <= LOCKED;
						end
						matchCnt <= matchCnt + lockCnt_t'(1);
					end
					LOCKED: state <= LOCKED;
					default: state <= UNLOCKED;
				endcase
			end
		end
	end

	assign instLock = (state == LOCKED);

endmodule

`default_nettype wire

// File: hw/pllCore.sv
// PLL core feedback path
`timescale 1ns/1ns
`default_nettype none

module pllCore import etrocPllPkg::*; (
	input  logic       clk2g56,
	input  logic       rstN,
	input  logic       enablePll,
	input  logic       skipA,
	input  logic       skipB,
	input  logic       skipC,
	input  logic [2:0] clkTreeADisable,
	input  logic [2:0] clkTreeBDisable,
	input  logic [2:0] clkTreeCDisable,
	input  logic       clk40Ref,
	output logic       clk1G28,
	output logic       clk320M,
	output logic       clk40M,
	output logic       clk40Mfb,
	output logic       tmrErr,
	output logic       instLock
);

	fbCount_t fbCount;
	logic     wrapPulse;
	logic     clk1G28Raw;
	logic     clk320MRaw;
	logic     clk40MRaw;

	//////////////////////////////
	// divider
	//////////////////////////////

	fbDividerTmr uDivider (
		.clk2g56    (clk2g56),
		.rstN       (rstN),
		.enablePll  (enablePll),
		.skipA      (skipA),
		.skipB      (skipB),
		.skipC      (skipC),
		.fbCount    (fbCount),
		.wrapPulse  (wrapPulse),
		.clk1G28Raw (clk1G28Raw),
		.clk320MRaw (clk320MRaw),
		.clk40MRaw  (clk40MRaw),
		.tmrErr     (tmrErr)
	);

	// loop feedback never goes through a tree gate
	assign clk40Mfb = clk40MRaw;

	//////////////////////////////
	// clock trees
	//////////////////////////////

	// tree A 1.28 GHz
	clkTreeGate uTreeA (
		.clk2g56     (clk2g56),
		.rstN        (rstN),
		.treeDisable (clkTreeADisable),
		.wrapPulse   (wrapPulse),
		.clkIn       (clk1G28Raw),
		.clkOut      (clk1G28)
	);

	// tree B 320 MHz
	clkTreeGate uTreeB (
		.clk2g56     (clk2g56),
		.rstN        (rstN),
		.treeDisable (clkTreeBDisable),
		.wrapPulse   (wrapPulse),
		.clkIn       (clk320MRaw),
		.clkOut      (clk320M)
	);

	// tree C 40 MHz
	clkTreeGate uTreeC (
		.clk2g56     (clk2g56),
		.rstN        (rstN),
		.treeDisable (clkTreeCDisable),
		.wrapPulse   (wrapPulse),
		.clkIn       (clk40MRaw),
		.clkOut      (clk40M)
	);

	//////////////////////////////
	// lock
	//////////////////////////////

	lockDetector uLock (
		.clk2g56   (clk2g56),
		.rstN      (rstN),
		.enablePll (enablePll),
		.clk40Ref  (clk40Ref),
		.fbCount   (fbCount),
		.instLock  (instLock)
	);

endmodule

`default_nettype wire

// File: verification/pllCoreTests.svh
// PLL core directed tests

function automatic int unsigned randomValue();
	rngState = rngState * 32'd1664525 + 32'd1013904223;
	return {16'd0, rngState[31:16]};
endfunction

function automatic string clockName(input int idx);
	case (idx)
		IDX_1G28: return "clk1G28";
		IDX_320M: return "clk320M";
		IDX_40M:  return "clk40M";
		default:  return "clk40Mfb";
	endcase
endfunction

task automatic checkValue(input string name, input int expected, input int actual);
	if (expected != actual) begin
		$display("** Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
		errors++;
	end
endtask

task automatic waitCycles(input int n);
	repeat (n) @(negedge clk2g56);
endtask

// returns at the posedge after the edge was recorded
task automatic waitRise(input int idx, input int limit);
	int startCount;
	int n;
	@(posedge clk2g56);
	startCount = riseCount[idx];
	n = 0;
	while (riseCount[idx] == startCount && n < limit) begin
		@(posedge clk2g56);
		n++;
	end
	if (riseCount[idx] == startCount) begin
		$display("no rising edge on %s within %0d cycles", clockName(idx), limit);
		errors++;
	end
endtask

task automatic applyReset();
	int releaseCycle;
	@(negedge clk2g56);
	rstN = 1'b0;
	waitCycles(2);
	checkValue("{clk1G28, clk320M, clk40M, clk40Mfb, tmrErr, instLock} in reset", 0,
		int'({clk1G28, clk320M, clk40M, clk40Mfb, tmrErr, instLock}));
	rstN = 1'b1;
	releaseCycle = cycle;
	waitRise(IDX_FB, 2 * DIV_RATIO);
	checkValue("clk40Mfb first rise", DIV_RATIO / 2 + 1, lastRise[IDX_FB] - releaseCycle);
endtask

task automatic divisionTest();
	int expPeriod;
	repeat (2) begin
		waitCycles(2 * DIV_RATIO);
		@(posedge clk2g56);
		for (int i = 0; i < 4; i++) begin
			expPeriod = (i == IDX_1G28) ? 2 : (i == IDX_320M) ? 8 : DIV_RATIO;
			checkValue($sformatf("%s period", clockName(i)), expPeriod, period[i]);
			checkValue($sformatf("%s high time", clockName(i)), expPeriod / 2, highTime[i]);
		end
	end
endtask

task automatic skipPulse(input logic [2:0] lanes, input int cycles);
	@(negedge clk2g56);
	{skipC, skipB, skipA} = lanes;
	waitCycles(cycles);
	{skipC, skipB, skipA} = 3'b000;
endtask

task automatic skipPeriodTest(input logic [2:0] lanes, input int expPeriod);
	waitRise(IDX_FB, 2 * DIV_RATIO);
	skipPulse(lanes, 1);
	waitRise(IDX_FB, 2 * DIV_RATIO);
	checkValue("clk40Mfb period with skip", expPeriod, period[IDX_FB]);
	waitRise(IDX_FB, 2 * DIV_RATIO);
	checkValue("clk40Mfb period after skip", DIV_RATIO, period[IDX_FB]);
endtask

task automatic skipTest();
	int lane;
	skipPeriodTest(3'b111, DIV_RATIO + 1);
	@(negedge clk2g56);
	checkValue("tmrErr", 0, int'(tmrErr));
	skipPeriodTest(3'b011, DIV_RATIO + 1);
	// lone skip on a random lane is outvoted
	lane = int'(randomValue() % 3);
	skipPeriodTest(3'b001 << lane, DIV_RATIO);
	@(negedge clk2g56);
	checkValue("tmrErr", 1, int'(tmrErr));
endtask

task automatic countRises(input int cycles, output int fbRises, output int gatedRises);
	int fbStart;
	int gatedStart;
	@(posedge clk2g56);
	fbStart = riseCount[IDX_FB];
	gatedStart = riseCount[IDX_40M];
	repeat (cycles) @(posedge clk2g56);
	fbRises = riseCount[IDX_FB] - fbStart;
	gatedRises = riseCount[IDX_40M] - gatedStart;
endtask

task automatic treeGateTest();
	int fbRises;
	int gatedRises;
	// one copy is outvoted
	@(negedge clk2g56);
	clkTreeCDisable = 3'b100;
	waitCycles(DIV_RATIO + 6);
	countRises(2 * DIV_RATIO, fbRises, gatedRises);
	checkValue("clk40M rises, one copy set", 2, gatedRises);
	@(negedge clk2g56);
	clkTreeCDisable = 3'b101;
	waitCycles(DIV_RATIO + 6);
	countRises(2 * DIV_RATIO, fbRises, gatedRises);
	checkValue("clk40Mfb rises, tree C off", 2, fbRises);
	checkValue("clk40M rises, tree C off", 0, gatedRises);
	checkValue("clk320M period, tree C off", 8, period[IDX_320M]);
	checkValue("clk1G28 period, tree C off", 2, period[IDX_1G28]);
	@(negedge clk2g56);
	checkValue("clk40M, tree C off", 0, int'(clk40M));
	clkTreeCDisable = 3'b000;
	waitCycles(DIV_RATIO + 6);
	countRises(2 * DIV_RATIO, fbRises, gatedRises);
	checkValue("clk40M rises, tree C on", 2, gatedRises);
	// gate register delay behind the feedback
	waitRise(IDX_40M, 2 * DIV_RATIO);
	checkValue("clk40M lag to clk40Mfb", 1, lastRise[IDX_40M] - lastRise[IDX_FB]);
endtask

// reference rises shift cycles after the feedback clock
task automatic alignReference(input int shift);
	waitRise(IDX_FB, 2 * DIV_RATIO);
	refOffset = (2 * DIV_RATIO - ((lastRise[IDX_FB] + shift) % DIV_RATIO)) % DIV_RATIO;
	refEnable = 1'b1;
endtask

task automatic lockTest();
	int shift;
	@(negedge clk2g56);
	checkValue("instLock before reference", 0, int'(instLock));
	shift = int'(randomValue() % 3) - PHASE_WINDOW;
	alignReference(shift);
	waitCycles((LOCK_COUNT + 1) * DIV_RATIO);
	checkValue("instLock after acquisition", 1, int'(instLock));
endtask

task automatic lockLossTest();
	// the first moved edge comes a few cycles in, the second one period later
	alignReference(5);
	waitCycles(DIV_RATIO);
	checkValue("instLock, phase moved", 0, int'(instLock));
	alignReference(0);
	waitCycles((LOCK_COUNT + 1) * DIV_RATIO);
	checkValue("instLock, phase restored", 1, int'(instLock));
	waitRise(IDX_FB, 2 * DIV_RATIO);
	skipPulse(3'b011, PHASE_WINDOW + 1);
	waitCycles(DIV_RATIO + 4);
	checkValue("instLock after skip", 0, int'(instLock));
endtask

task automatic enableTest();
	logic [4:0] seen;
	int         startCycle;
	seen = 5'b00000;
	// relock first so the disable has a lock to drop
	alignReference(0);
	waitCycles((LOCK_COUNT + 1) * DIV_RATIO);
	checkValue("instLock before disable", 1, int'(instLock));
	@(negedge clk2g56);
	enablePll = 1'b0;
	waitCycles(4);
	repeat (DIV_RATIO) begin
		@(negedge clk2g56);
		seen = seen | {clk1G28, clk320M, clk40M, clk40Mfb, instLock};
	end
	checkValue("{clk1G28, clk320M, clk40M, clk40Mfb, instLock} while disabled", 0,
		int'(seen));
	enablePll = 1'b1;
	startCycle = cycle;
	waitRise(IDX_FB, 2 * DIV_RATIO);
	checkValue("clk40Mfb first rise after enable", DIV_RATIO / 2 + 1,
		lastRise[IDX_FB] - startCycle);
endtask

// File: verification/pllCoreTb.sv
// PLL core testbench
`timescale 1ns/1ns
`default_nettype none

module pllCoreTb import etrocPllPkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int IDX_1G28 = 0;
	localparam int IDX_320M = 1;
	localparam int IDX_40M = 2;
	localparam int IDX_FB = 3;
	// about 61 reference periods of tests plus a margin
	localparam int WATCHDOG_NS = 75 * DIV_RATIO * CLK_PERIOD;

	logic       clk2g56;
	logic       rstN;
	logic       enablePll;
	logic       skipA;
	logic       skipB;
	logic       skipC;
	logic [2:0] clkTreeADisable;
	logic [2:0] clkTreeBDisable;
	logic [2:0] clkTreeCDisable;
	logic       clk40Ref;
	logic       clk1G28;
	logic       clk320M;
	logic       clk40M;
	logic       clk40Mfb;
	logic       tmrErr;
	logic       instLock;

	int          cycle = 0;
	int          errors = 0;
	bit   [31:0] rngState = 32'hfc5c134e;
	int          refOffset = 0;
	logic        refEnable = 1'b0;
	logic [3:0]  clkBus;
	logic [3:0]  clkPrev = 4'b0000;
	int          riseCount [4];
	int          lastRise [4];
	int          period [4];
	int          highTime [4];

	pllCore u_dut (
		.clk2g56         (clk2g56),
		.rstN            (rstN),
		.enablePll       (enablePll),
		.skipA           (skipA),
		.skipB           (skipB),
		.skipC           (skipC),
		.clkTreeADisable (clkTreeADisable),
		.clkTreeBDisable (clkTreeBDisable),
		.clkTreeCDisable (clkTreeCDisable),
		.clk40Ref        (clk40Ref),
		.clk1G28         (clk1G28),
		.clk320M         (clk320M),
		.clk40M          (clk40M),
		.clk40Mfb        (clk40Mfb),
		.tmrErr          (tmrErr),
		.instLock        (instLock)
	);

	`include "pllCoreTests.svh"

	//////////////////////////////
	// clock and cycle count
	//////////////////////////////

	initial begin
		clk2g56 = 1'b0;
		forever #(CLK_PERIOD / 2) clk2g56 = ~clk2g56;
	end

	always @(posedge clk2g56) begin
		cycle <= cycle + 1;
	end

	// reference with the phase chosen by the tests
	initial begin
		clk40Ref = 1'b0;
		forever begin
			@(negedge clk2g56);
			clk40Ref = refEnable && (((cycle + refOffset) % DIV_RATIO) < DIV_RATIO / 2);
		end
	end

	//////////////////////////////
	// edge monitors
	//////////////////////////////

	assign clkBus = {clk40Mfb, clk40M, clk320M, clk1G28};

	always @(negedge clk2g56) begin
		for (int i = 0; i < 4; i++) begin
			if (clkBus[i] && !clkPrev[i]) begin
				period[i] = cycle - lastRise[i];
				lastRise[i] = cycle;
				riseCount[i] = riseCount[i] + 1;
			end
			if (!clkBus[i] && clkPrev[i]) begin
				highTime[i] = cycle - lastRise[i];
			end
		end
		clkPrev = clkBus;
	end

	//////////////////////////////
	// sequence and report
	//////////////////////////////

	initial begin
		rstN = 1'b0;
		enablePll = 1'b1;
		{skipC, skipB, skipA} = 3'b000;
		clkTreeADisable = 3'b000;
		clkTreeBDisable = 3'b000;
		clkTreeCDisable = 3'b000;
		applyReset();
		divisionTest();
		skipTest();
		applyReset();
		treeGateTest();
		lockTest();
		lockLossTest();
		enableTest();
		$display("tests finished with %0d errors", errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished, %0d errors", errors);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: etrocPll.f
+incdir+verification
hw/etrocPllPkg.sv
hw/fbDividerLane.sv
hw/fbDividerTmr.sv
hw/clkTreeGate.sv
hw/lockDetector.sv
hw/pllCore.sv
verification/pllCoreTb.sv

// File: Makefile
# Verilator build for the PLL feedback path

VERILATOR ?= verilator
VFLAGS    := --timing
TOP       := pllCoreTb
FILELIST  := etrocPll.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q ">>> PASS" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
